/* logic/hyper_udma_pkg.sv */
/*
 * HyperBus uDMA bridge definitions
 * Word, async FIFO and prefetch types shared by the TX and RX paths
 */
package hyper_udma_pkg;

    // uDMA data word
    localparam int unsigned DATA_WIDTH = 32;
    typedef logic [DATA_WIDTH-1:0] word_t;

    // Async FIFO with 8 entries, pointers carry one wrap bit
    localparam int unsigned FIFO_LOG_DEPTH = 3;
    typedef logic [FIFO_LOG_DEPTH:0] ptr_t;
    typedef word_t [2**FIFO_LOG_DEPTH-1:0] fifo_mem_t;

    // Flops per pointer synchronizer
    localparam int unsigned SYNC_STAGES = 2;

    // Stored plus outstanding L2 reads
    localparam int unsigned PREFETCH_DEPTH = 4;
    typedef logic [$clog2(PREFETCH_DEPTH+1)-1:0] prefetch_cnt_t;

endpackage

/* logic/udma_tx_prefetch.sv */
`timescale 1ns/1ns
/*
 * uDMA TX prefetch buffer
 * Issues L2 read requests ahead of the TX stream and keeps the returned
 * words in a small FIFO. Requests stop while every slot is taken.
 */
module udma_tx_prefetch (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    output logic                  req_o,
    input  logic                  gnt_i,
    input  hyper_udma_pkg::word_t data_i,
    input  logic                  valid_i,
    output logic                  ready_o,
    output hyper_udma_pkg::word_t data_o,
    output logic                  valid_o,
    input  logic                  ready_i
);
    import hyper_udma_pkg::*;

    word_t                             mem_q [PREFETCH_DEPTH];
    logic [$clog2(PREFETCH_DEPTH)-1:0] wr_idx_q;
    logic [$clog2(PREFETCH_DEPTH)-1:0] rd_idx_q;
    prefetch_cnt_t                     stored_q;
    prefetch_cnt_t                     stored_d;
    prefetch_cnt_t                     pending_q;
    prefetch_cnt_t                     pending_d;
    logic                              req_q;
    logic                              grant;
    logic                              push;
    logic                              pop;

    assign grant = req_q && gnt_i;
    assign push  = valid_i && ready_o;
    assign pop   = valid_o && ready_i;

    // Every answer retires one granted request
    assign stored_d  = stored_q + prefetch_cnt_t'(push) - prefetch_cnt_t'(pop);
    assign pending_d = pending_q + prefetch_cnt_t'(grant) - prefetch_cnt_t'(push);

    assign req_o   = req_q;
    assign ready_o = stored_q < PREFETCH_DEPTH;
    assign valid_o = stored_q != '0;
    assign data_o  = mem_q[rd_idx_q];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            stored_q  <= '0;
            pending_q <= '0;
            wr_idx_q  <= '0;
            rd_idx_q  <= '0;
            req_q     <= 1'b0;
        end else begin
            stored_q  <= stored_d;
            pending_q <= pending_d;
            // Request again only if a slot stays free for the answer
            req_q     <= (stored_d + pending_d) < PREFETCH_DEPTH;
            if (push) begin
                wr_idx_q <= wr_idx_q + 1'b1;
            end
            if (pop) begin
                rd_idx_q <= rd_idx_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_idx_q] <= data_i;
        end
    end

endmodule

/* logic/cdc_gray_src.sv */
`timescale 1ns/1ns
/*
 * Async FIFO write side
 * Holds the storage and the gray write pointer, and checks for a full
 * FIFO against the read pointer brought over from the other clock.
 */
module cdc_gray_src (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  hyper_udma_pkg::word_t     data_i,
    input  logic                      valid_i,
    output logic                      ready_o,
    output hyper_udma_pkg::fifo_mem_t async_data_o,
    output hyper_udma_pkg::ptr_t      async_wptr_o,
    input  hyper_udma_pkg::ptr_t      async_rptr_i
);
    import hyper_udma_pkg::*;

    fifo_mem_t                 mem_q;
    ptr_t                      wptr_bin_q;
    ptr_t                      wptr_bin_d;
    ptr_t                      wptr_gray_q;
    ptr_t                      wptr_gray_d;
    ptr_t [SYNC_STAGES-1:0]    rptr_sync_q;
    ptr_t                      rptr_full;
    logic                      ready_q;
    logic                      push;

    assign push = valid_i && ready_o;

    assign wptr_bin_d  = wptr_bin_q + ptr_t'(push);
    assign wptr_gray_d = wptr_bin_d ^ (wptr_bin_d >> 1);

    // Full when gray pointers differ only in the two top bits
    assign rptr_full = rptr_sync_q[SYNC_STAGES-2] ^ {2'b11, {(FIFO_LOG_DEPTH-1){1'b0}}};

    assign ready_o      = ready_q;
    assign async_data_o = mem_q;
    assign async_wptr_o = wptr_gray_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wptr_bin_q  <= '0;
            wptr_gray_q <= '0;
            rptr_sync_q <= '0;
            ready_q     <= 1'b0;
        end else begin
            wptr_bin_q  <= wptr_bin_d;
            wptr_gray_q <= wptr_gray_d;
            rptr_sync_q <= {rptr_sync_q[SYNC_STAGES-2:0], async_rptr_i};
            // Same test as on the next synchronized pointer
            ready_q     <= wptr_gray_d != rptr_full;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wptr_bin_q[FIFO_LOG_DEPTH-1:0]] <= data_i;
        end
    end

endmodule

/* logic/cdc_gray_dst.sv */
`timescale 1ns/1ns
/*
 * Async FIFO read side
 * Brings the gray write pointer into the local clock and offers the
 * oldest word on a valid/ready stream.
 */
module cdc_gray_dst (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    output hyper_udma_pkg::word_t     data_o,
    output logic                      valid_o,
    input  logic                      ready_i,
    input  hyper_udma_pkg::fifo_mem_t async_data_i,
    input  hyper_udma_pkg::ptr_t      async_wptr_i,
    output hyper_udma_pkg::ptr_t      async_rptr_o
);
    import hyper_udma_pkg::*;

    ptr_t [SYNC_STAGES-1:0]    wptr_sync_q;
    ptr_t                      rptr_bin_q;
    ptr_t                      rptr_bin_d;
    ptr_t                      rptr_gray_q;
    ptr_t                      rptr_gray_d;
    logic                      pop;

    // Not empty once the write pointer has passed the synchronizer
    assign valid_o = wptr_sync_q[SYNC_STAGES-1] != rptr_gray_q;
    assign pop     = valid_o && ready_i;

    assign rptr_bin_d  = rptr_bin_q + ptr_t'(pop);
    assign rptr_gray_d = rptr_bin_d ^ (rptr_bin_d >> 1);

    // Slot stays untouched until the read pointer moves past it
    assign data_o       = async_data_i[rptr_bin_q[FIFO_LOG_DEPTH-1:0]];
    assign async_rptr_o = rptr_gray_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wptr_sync_q <= '0;
            rptr_bin_q  <= '0;
            rptr_gray_q <= '0;
        end else begin
            wptr_sync_q <= {wptr_sync_q[SYNC_STAGES-2:0], async_wptr_i};
            rptr_bin_q  <= rptr_bin_d;
            rptr_gray_q <= rptr_gray_d;
        end
    end

endmodule

/* logic/hyper_udma_bridge.sv */
`timescale 1ns/1ns
/*
 * HyperBus uDMA data bridge
 * TX: L2 prefetch in the system clock, then async FIFO to the PHY stream
 * RX: PHY stream through an async FIFO to the uDMA data_rx stream
 */
module hyper_udma_bridge (
    input  logic                  clk_sys_i,
    input  logic                  clk_phy_i,
    input  logic                  rst_n_i,
    // L2 read side
    output logic                  data_tx_req_o,
    input  logic                  data_tx_gnt_i,
    input  hyper_udma_pkg::word_t data_tx_i,
    input  logic                  data_tx_valid_i,
    output logic                  data_tx_ready_o,
    // PHY TX stream
    output hyper_udma_pkg::word_t phy_tx_data_o,
    output logic                  phy_tx_valid_o,
    input  logic                  phy_tx_ready_i,
    // PHY RX stream
    input  hyper_udma_pkg::word_t phy_rx_data_i,
    input  logic                  phy_rx_valid_i,
    output logic                  phy_rx_ready_o,
    // uDMA RX stream
    output hyper_udma_pkg::word_t data_rx_o,
    output logic                  data_rx_valid_o,
    input  logic                  data_rx_ready_i
);
    import hyper_udma_pkg::*;

    word_t     tx_pf_data;
    logic      tx_pf_valid;
    logic      tx_pf_ready;

    fifo_mem_t tx_async_data;
    ptr_t      tx_async_wptr;
    ptr_t      tx_async_rptr;

    fifo_mem_t rx_async_data;
    ptr_t      rx_async_wptr;
    ptr_t      rx_async_rptr;

    udma_tx_prefetch i_tx_prefetch (
        .clk_i   ( clk_sys_i       ),
        .rst_n_i ( rst_n_i         ),
        .req_o   ( data_tx_req_o   ),
        .gnt_i   ( data_tx_gnt_i   ),
        .data_i  ( data_tx_i       ),
        .valid_i ( data_tx_valid_i ),
        .ready_o ( data_tx_ready_o ),
        .data_o  ( tx_pf_data      ),
        .valid_o ( tx_pf_valid     ),
        .ready_i ( tx_pf_ready     )
    );

    cdc_gray_src i_tx_src (
        .clk_i        ( clk_sys_i     ),
        .rst_n_i      ( rst_n_i       ),
        .data_i       ( tx_pf_data    ),
        .valid_i      ( tx_pf_valid   ),
        .ready_o      ( tx_pf_ready   ),
        .async_data_o ( tx_async_data ),
        .async_wptr_o ( tx_async_wptr ),
        .async_rptr_i ( tx_async_rptr )
    );

    cdc_gray_dst i_tx_dst (
        .clk_i        ( clk_phy_i      ),
        .rst_n_i      ( rst_n_i        ),
        .data_o       ( phy_tx_data_o  ),
        .valid_o      ( phy_tx_valid_o ),
        .ready_i      ( phy_tx_ready_i ),
        .async_data_i ( tx_async_data  ),
        .async_wptr_i ( tx_async_wptr  ),
        .async_rptr_o ( tx_async_rptr  )
    );

    cdc_gray_src i_rx_src (
        .clk_i        ( clk_phy_i      ),
        .rst_n_i      ( rst_n_i        ),
        .data_i       ( phy_rx_data_i  ),
        .valid_i      ( phy_rx_valid_i ),
        .ready_o      ( phy_rx_ready_o ),
        .async_data_o ( rx_async_data  ),
        .async_wptr_o ( rx_async_wptr  ),
        .async_rptr_i ( rx_async_rptr  )
    );

    cdc_gray_dst i_rx_dst (
        .clk_i        ( clk_sys_i       ),
        .rst_n_i      ( rst_n_i         ),
        .data_o       ( data_rx_o       ),
        .valid_o      ( data_rx_valid_o ),
        .ready_i      ( data_rx_ready_i ),
        .async_data_i ( rx_async_data   ),
        .async_wptr_i ( rx_async_wptr   ),
        .async_rptr_o ( rx_async_rptr   )
    );

endmodule

/* bench/hyper_udma_bridge_props.sv */
`timescale 1ns/1ns
/*
 * Bound checks for the uDMA bridge stages
 * Gray pointer steps, stream stability and the prefetch request limit
 */
module hyper_udma_bridge_props (
    input logic                          clk_i,
    input logic                          rst_n_i,
    input hyper_udma_pkg::ptr_t          ptr_i,
    input logic                          valid_i,
    input logic                          ready_i,
    input hyper_udma_pkg::word_t         data_i,
    input hyper_udma_pkg::prefetch_cnt_t stored_i,
    input hyper_udma_pkg::prefetch_cnt_t pending_i
);
    import hyper_udma_pkg::*;

    gray_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $countones(ptr_i ^ $past(ptr_i)) <= 1)
        else $error("Gray pointer changed in more than one bit");

    // Offered word must wait for ready
    stream_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i && !ready_i |=> valid_i && $stable(data_i))
        else $error("Stream valid dropped or data changed before the transfer");

    prefetch_limit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        int'(stored_i) + int'(pending_i) <= PREFETCH_DEPTH)
        else $error("Prefetch stored plus outstanding words exceed the depth");

endmodule

bind udma_tx_prefetch hyper_udma_bridge_props i_prefetch_props (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .ptr_i('0), .valid_i(valid_o), .ready_i(ready_i),
    .data_i(data_o), .stored_i(stored_q), .pending_i(pending_q));

bind cdc_gray_src hyper_udma_bridge_props i_src_props (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .ptr_i(wptr_gray_q), .valid_i(valid_i),
    .ready_i(ready_o), .data_i(data_i), .stored_i('0), .pending_i('0));

bind cdc_gray_dst hyper_udma_bridge_props i_dst_props (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .ptr_i(rptr_gray_q), .valid_i(valid_o),
    .ready_i(ready_i), .data_i(data_o), .stored_i('0), .pending_i('0));

/* bench/tb_hyper_udma_bridge.sv */
`timescale 1ns/1ns
/*
 * Testbench for the HyperBus uDMA data bridge
 * L2 and PHY models on two drifting clocks, stalls and in-order checks
 */
module tb_hyper_udma_bridge;
    import hyper_udma_pkg::*;

    localparam int unsigned N_WORDS = 200;
    localparam int L2_RNG = 0;
    localparam int TX_SINK_RNG = 1;
    localparam int RX_SRC_RNG = 2;
    localparam int RX_SINK_RNG = 3;

    logic  clk_sys_i = 1'b0;
    logic  clk_phy_i = 1'b0;
    logic  rst_n_i;
    logic  data_tx_req_o, data_tx_gnt_i, data_tx_valid_i, data_tx_ready_o;
    word_t data_tx_i, phy_tx_data_o, phy_rx_data_i, data_rx_o;
    logic  phy_tx_valid_o, phy_tx_ready_i, phy_rx_valid_i, phy_rx_ready_o;
    logic  data_rx_valid_o, data_rx_ready_i;

    // One LFSR per stimulus process
    logic [31:0] lfsr_state [4] = '{4{32'h657020ae}};
    int unsigned granted = 0, answered = 0, tx_rcv = 0, rx_sent = 0, rx_rcv = 0;
    int unsigned tx_stalls = 0, rx_stalls = 0;

    always #10 clk_sys_i = ~clk_sys_i;
    always #13 clk_phy_i = ~clk_phy_i;

    hyper_udma_bridge UUT (
        .clk_sys_i(clk_sys_i), .clk_phy_i(clk_phy_i), .rst_n_i(rst_n_i),
        .data_tx_req_o(data_tx_req_o), .data_tx_gnt_i(data_tx_gnt_i),
        .data_tx_i(data_tx_i), .data_tx_valid_i(data_tx_valid_i),
        .data_tx_ready_o(data_tx_ready_o), .phy_tx_data_o(phy_tx_data_o),
        .phy_tx_valid_o(phy_tx_valid_o), .phy_tx_ready_i(phy_tx_ready_i),
        .phy_rx_data_i(phy_rx_data_i), .phy_rx_valid_i(phy_rx_valid_i),
        .phy_rx_ready_o(phy_rx_ready_o), .data_rx_o(data_rx_o),
        .data_rx_valid_o(data_rx_valid_o), .data_rx_ready_i(data_rx_ready_i)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic logic [31:0] rand_bits(input int src, input int n);
        logic [31:0] bits;
        int          i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state[src] = lfsr_step(lfsr_state[src]);
            bits = {bits[30:0], lfsr_state[src][0]};
        end
        return bits;
    endfunction

    // n-th word of the test sequence, same for both paths
    function automatic word_t ref_word(input int unsigned n);
        return (n * 32'h9e37_79b1) ^ 32'h5a3c_96e1;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    initial begin : main
        rst_n_i = 1'b0;
        data_tx_gnt_i = 1'b0;
        data_tx_valid_i = 1'b0;
        data_tx_i = '0;
        phy_tx_ready_i = 1'b0;
        phy_rx_valid_i = 1'b0;
        phy_rx_data_i = '0;
        data_rx_ready_i = 1'b0;
        repeat (2) @(negedge clk_sys_i);
        repeat (8) begin
            @(negedge clk_sys_i);
            assert (!data_tx_req_o && !phy_tx_valid_o && !data_rx_valid_o && !phy_rx_ready_o)
                else stop_on_error("An output was active during reset");
        end
        rst_n_i = 1'b1;
        wait (tx_rcv == N_WORDS && rx_rcv == N_WORDS);
        // Drain time to catch extra words
        repeat (50) @(posedge clk_sys_i);
        if (tx_stalls == 2 && rx_stalls == 2) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stop_on_error("Not every stall phase was completed");
        end
    end

    initial begin : watchdog
        repeat (N_WORDS * 40 + 2000) @(posedge clk_sys_i);
        stop_on_error($sformatf("Timeout with %0d TX and %0d RX words of %0d delivered",
                                tx_rcv, rx_rcv, N_WORDS));
    end

    // L2 model, answers in grant order with 0 to 3 idle cycles
    initial begin : l2_model
        int unsigned due_q [$];
        int unsigned cycle;
        int unsigned last_due;
        int unsigned due;
        cycle = 0;
        last_due = 0;
        @(posedge rst_n_i);
        forever begin
            @(negedge clk_sys_i);
            cycle++;
            assert (granted - answered <= PREFETCH_DEPTH)
                else stop_on_error("More L2 requests outstanding than the prefetch depth");
            data_tx_valid_i = 1'b0;
            if (due_q.size() > 0 && due_q[0] <= cycle) begin
                void'(due_q.pop_front());
                data_tx_valid_i = 1'b1;
                data_tx_i = ref_word(answered);
                answered++;
                assert (data_tx_ready_o)
                    else stop_on_error("L2 answer driven while data_tx_ready_o is low");
            end
            data_tx_gnt_i = (granted < N_WORDS) && rand_bits(L2_RNG, 1);
            if (data_tx_gnt_i && data_tx_req_o) begin
                // Delay runs from the grant or from the previous answer
                due = ((last_due > cycle) ? last_due : cycle) + 1 + rand_bits(L2_RNG, 2);
                due_q.push_back(due);
                last_due = due;
                granted++;
            end
        end
    end

    initial begin : tx_sink
        int stall_left;
        int next_stall;
        stall_left = 0;
        next_stall = 50;
        @(posedge rst_n_i);
        forever begin
            @(negedge clk_phy_i);
            if (stall_left == 0 && tx_rcv == next_stall) begin
                stall_left = 100;
                next_stall += 80;
            end
            if (stall_left > 0) begin
                phy_tx_ready_i = 1'b0;
                stall_left--;
                if (stall_left == 0) begin
                    assert (!data_tx_req_o)
                        else stop_on_error("data_tx_req_o still high after a long TX stall");
                    tx_stalls++;
                end
            end else begin
                phy_tx_ready_i = |rand_bits(TX_SINK_RNG, 2);
            end
            if (phy_tx_valid_o && phy_tx_ready_i) begin
                assert (tx_rcv < N_WORDS)
                    else stop_on_error("TX path delivered more words than were sent");
                assert (phy_tx_data_o === ref_word(tx_rcv))
                    else stop_on_error($sformatf("FAIL at %0t: TX word %0d expected %h received %h",
                                                 $time, tx_rcv, ref_word(tx_rcv), phy_tx_data_o));
                tx_rcv++;
            end
        end
    end

    initial begin : rx_source
        logic ready_seen;
        ready_seen = 1'b0;
        @(posedge rst_n_i);
        forever begin
            @(negedge clk_phy_i);
            if (phy_rx_valid_i && ready_seen) begin
                rx_sent++;
                phy_rx_valid_i = 1'b0;
            end
            if (!phy_rx_valid_i && rx_sent < N_WORDS && rand_bits(RX_SRC_RNG, 1)) begin
                phy_rx_valid_i = 1'b1;
                phy_rx_data_i = ref_word(rx_sent);
            end
            ready_seen = phy_rx_ready_o;
        end
    end

    initial begin : rx_sink
        int stall_left;
        int next_stall;
        stall_left = 0;
        next_stall = 50;
        @(posedge rst_n_i);
        forever begin
            @(negedge clk_sys_i);
            if (stall_left == 0 && rx_rcv == next_stall) begin
                stall_left = 100;
                next_stall += 80;
            end
            if (stall_left > 0) begin
                data_rx_ready_i = 1'b0;
                stall_left--;
                if (stall_left == 0) begin
                    assert (!phy_rx_ready_o)
                        else stop_on_error("phy_rx_ready_o still high after a long RX stall");
                    rx_stalls++;
                end
            end else begin
                data_rx_ready_i = |rand_bits(RX_SINK_RNG, 2);
            end
            if (data_rx_valid_o && data_rx_ready_i) begin
                assert (rx_rcv < N_WORDS)
                    else stop_on_error("RX path delivered more words than were sent");
                assert (data_rx_o === ref_word(rx_rcv))
                    else stop_on_error($sformatf("FAIL at %0t: RX word %0d expected %h received %h",
                                                 $time, rx_rcv, ref_word(rx_rcv), data_rx_o));
                rx_rcv++;
            end
        end
    end

endmodule

/* list.f */
logic/hyper_udma_pkg.sv
logic/udma_tx_prefetch.sv
logic/cdc_gray_src.sv
logic/cdc_gray_dst.sv
logic/hyper_udma_bridge.sv
bench/hyper_udma_bridge_props.sv
bench/tb_hyper_udma_bridge.sv

/* Bender.yml */
package:
  name: hyper_udma_bridge

sources:
  - logic/hyper_udma_pkg.sv
  - logic/udma_tx_prefetch.sv
  - logic/cdc_gray_src.sv
  - logic/cdc_gray_dst.sv
  - logic/hyper_udma_bridge.sv
  - target: test
    files:
      - bench/hyper_udma_bridge_props.sv
      - bench/tb_hyper_udma_bridge.sv
